/* hdl/cdb_pkg.sv */
// Completion stage definitions shared by result buffers, selector and CDB broadcast
package cdb_pkg;

    // Functional unit population
    localparam int fu_size      = 20;
    localparam int half_fu_size = fu_size / 2;
    localparam int num_cdb      = 2;

    // Categories in rising priority: alu, load/store, mult, branch
    localparam int fu_cat      = 4;
    localparam int alu_offset  = 8;
    localparam int ls_offset   = 12;
    localparam int mult_offset = 16;
    localparam int beq_offset  = 20;

    // Category boundaries over both halves together
    localparam int cat_bound [fu_cat+1] = '{0, alu_offset, ls_offset, mult_offset, beq_offset};

    typedef logic [63:0]             data_t;
    typedef logic [5:0]              phys_reg_t;
    typedef logic [4:0]              rob_idx_t;
    typedef logic [4:0]              fu_num_t;
    typedef logic [1:0]              rot_cnt_t;
    typedef logic [fu_size-1:0]      fu_mask_t;
    typedef logic [half_fu_size-1:0] half_mask_t;
    typedef logic [fu_cat-1:0]       cat_mask_t;

    // Half position to FU slot, grouped by category in ascending order
    localparam fu_num_t slot_map [num_cdb][half_fu_size] = '{
        '{0, 2, 4, 6, 9, 11, 12, 14, 17, 19},
        '{1, 3, 5, 7, 8, 10, 13, 15, 16, 18}
    };

    typedef struct packed {
        data_t     value;
        phys_reg_t tag;
        rob_idx_t  rob_idx;
    } fu_result_t;

    typedef struct packed {
        logic      valid;
        fu_num_t   fu_num;
        data_t     value;
        phys_reg_t tag;
        rob_idx_t  rob_idx;
    } cdb_packet_t;

endpackage

/* hdl/rotating_priority_selector.sv */
// One-hot grant among a small request group, search start rotated by a count

`timescale 1ns/1ps

module rotating_priority_selector
    import cdb_pkg::*;
#(
    parameter int width = 4
) (
    input  rot_cnt_t         cnt,
    input  logic [width-1:0] req,
    input  logic             en,
    output logic [width-1:0] gnt
);

    int   start;
    int   idx;
    logic found;

    always_comb begin
        gnt   = '0;
        found = 1'b0;
        start = int'(cnt) % width;
        idx   = 0;
        // Walk once around the group from the rotated start
        for (int i = 0; i < width; i++) begin
            idx = (start + i) % width;
            if (en && !found && req[idx]) begin
                gnt[idx] = 1'b1;
                found    = 1'b1;
            end
        end
    end

endmodule

/* hdl/fu_result_buffer.sv */
// Per-FU result holding slots, filled on done and freed when granted to a CDB

`timescale 1ns/1ps

module fu_result_buffer
    import cdb_pkg::*;
(
    input  logic       clock,
    input  logic       reset,

    input  fu_mask_t   fu_done,
    input  fu_result_t fu_result [fu_size],

    input  fu_num_t    fu_num_0,
    input  fu_num_t    fu_num_1,
    input  cat_mask_t  cat_select_0,
    input  cat_mask_t  cat_select_1,

    output fu_mask_t   buffer_valid,
    output fu_result_t buffered_results [fu_size],
    output fu_mask_t   fu_ready
);

    fu_mask_t granted;

    // A half grants only when some category won there
    always_comb begin
        granted = '0;
        if (|cat_select_0) begin
            granted[fu_num_0] = 1'b1;
        end
        if (|cat_select_1) begin
            granted[fu_num_1] = 1'b1;
        end
    end

    // Slot is free now, or frees at the coming edge
    assign fu_ready = ~buffer_valid | granted;

    always_ff @(posedge clock) begin
        if (reset) begin
            buffer_valid <= '0;
        end else begin
            buffer_valid <= (buffer_valid & ~granted) | fu_done;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < fu_size; i++) begin
            if (fu_done[i]) begin
                buffered_results[i] <= fu_result[i];
            end
        end
    end

endmodule

/* hdl/fu_selector_2.sv */
// Two-way completion selector, fixed category priority with rotation inside each category

`timescale 1ns/1ps

module fu_selector_2
    import cdb_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  fu_mask_t  buffer_valid,

    output fu_num_t   fu_num_0,
    output fu_num_t   fu_num_1,
    output cat_mask_t cat_select_0,
    output cat_mask_t cat_select_1
);

    rot_cnt_t   cnt;

    half_mask_t half_valid [num_cdb];
    cat_mask_t  cat_req    [num_cdb];
    cat_mask_t  cat_sel    [num_cdb];
    half_mask_t selection  [num_cdb];
    fu_num_t    fu_num     [num_cdb];

    // Free-running rotation shared by all groups
    always_ff @(posedge clock) begin
        if (reset) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    for (genvar h = 0; h < num_cdb; h++) begin : g_half

        // Gather this half's valids in category order
        always_comb begin
            for (int p = 0; p < half_fu_size; p++) begin
                half_valid[h][p] = buffer_valid[slot_map[h][p]];
            end
        end

        for (genvar c = 0; c < fu_cat; c++) begin : g_cat
            localparam int cat_lo    = cat_bound[c] / 2;
            localparam int cat_width = (cat_bound[c+1] - cat_bound[c]) / 2;

            assign cat_req[h][c] = |half_valid[h][cat_lo +: cat_width];

            // Only the winning category's group may grant
            rotating_priority_selector #(
                .width(cat_width)
            ) i_group_select (
                .cnt(cnt),
                .req(half_valid[h][cat_lo +: cat_width]),
                .en (cat_sel[h][c]),
                .gnt(selection[h][cat_lo +: cat_width])
            );
        end

        // Fixed priority, branch highest and alu lowest
        always_comb begin
            cat_sel[h] = '0;
            for (int c = 0; c < fu_cat; c++) begin
                if (cat_req[h][c]) begin
                    cat_sel[h]    = '0;
                    cat_sel[h][c] = 1'b1;
                end
            end
        end

        // One-hot position back to FU slot number
        always_comb begin
            fu_num[h] = slot_map[h][0];
            for (int p = 0; p < half_fu_size; p++) begin
                if (selection[h][p]) begin
                    fu_num[h] = slot_map[h][p];
                end
            end
        end

    end

    assign fu_num_0     = fu_num[0];
    assign fu_num_1     = fu_num[1];
    assign cat_select_0 = cat_sel[0];
    assign cat_select_1 = cat_sel[1];

endmodule

/* hdl/cdb_broadcast.sv */
// Registers the two selected buffered results onto the common data buses

`timescale 1ns/1ps

module cdb_broadcast
    import cdb_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    input  fu_result_t  buffered_results [fu_size],

    input  fu_num_t     fu_num_0,
    input  fu_num_t     fu_num_1,
    input  cat_mask_t   cat_select_0,
    input  cat_mask_t   cat_select_1,

    output cdb_packet_t cdb_0,
    output cdb_packet_t cdb_1
);

    fu_num_t    sel_num   [num_cdb];
    cat_mask_t  sel_cat   [num_cdb];

    logic       cdb_valid [num_cdb];
    fu_num_t    cdb_num   [num_cdb];
    fu_result_t cdb_data  [num_cdb];

    assign sel_num[0] = fu_num_0;
    assign sel_num[1] = fu_num_1;
    assign sel_cat[0] = cat_select_0;
    assign sel_cat[1] = cat_select_1;

    for (genvar h = 0; h < num_cdb; h++) begin : g_bus

        always_ff @(posedge clock) begin
            if (reset) begin
                cdb_valid[h] <= 1'b0;
            end else begin
                cdb_valid[h] <= |sel_cat[h];
            end
        end

        // Payload follows the mux even on idle cycles
        always_ff @(posedge clock) begin
            cdb_num[h]  <= sel_num[h];
            cdb_data[h] <= buffered_results[sel_num[h]];
        end

    end

    assign cdb_0 = '{valid:   cdb_valid[0],
                     fu_num:  cdb_num[0],
                     value:   cdb_data[0].value,
                     tag:     cdb_data[0].tag,
                     rob_idx: cdb_data[0].rob_idx};

    assign cdb_1 = '{valid:   cdb_valid[1],
                     fu_num:  cdb_num[1],
                     value:   cdb_data[1].value,
                     tag:     cdb_data[1].tag,
                     rob_idx: cdb_data[1].rob_idx};

endmodule

/* hdl/complete_stage.sv */
// Completion stage top, FU result buffers feeding two CDBs through the selector

`timescale 1ns/1ps

module complete_stage
    import cdb_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    input  fu_mask_t    fu_done,
    input  fu_result_t  fu_result [fu_size],
    output fu_mask_t    fu_ready,

    output cdb_packet_t cdb_0,
    output cdb_packet_t cdb_1
);

    fu_mask_t   buffer_valid;
    fu_result_t buffered_results [fu_size];

    fu_num_t    fu_num_0;
    fu_num_t    fu_num_1;
    cat_mask_t  cat_select_0;
    cat_mask_t  cat_select_1;

    fu_result_buffer i_fu_result_buffer (
        .clock           (clock),
        .reset           (reset),
        .fu_done         (fu_done),
        .fu_result       (fu_result),
        .fu_num_0        (fu_num_0),
        .fu_num_1        (fu_num_1),
        .cat_select_0    (cat_select_0),
        .cat_select_1    (cat_select_1),
        .buffer_valid    (buffer_valid),
        .buffered_results(buffered_results),
        .fu_ready        (fu_ready)
    );

    fu_selector_2 i_fu_selector_2 (
        .clock       (clock),
        .reset       (reset),
        .buffer_valid(buffer_valid),
        .fu_num_0    (fu_num_0),
        .fu_num_1    (fu_num_1),
        .cat_select_0(cat_select_0),
        .cat_select_1(cat_select_1)
    );

    cdb_broadcast i_cdb_broadcast (
        .clock           (clock),
        .reset           (reset),
        .buffered_results(buffered_results),
        .fu_num_0        (fu_num_0),
        .fu_num_1        (fu_num_1),
        .cat_select_0    (cat_select_0),
        .cat_select_1    (cat_select_1),
        .cdb_0           (cdb_0),
        .cdb_1           (cdb_1)
    );

endmodule

/* verification/complete_stage_tb.sv */
// Completion stage testbench with random FU model, reference scoreboard and bus checks

`timescale 1ns/1ps

module complete_stage_tb
    import cdb_pkg::*;
();

    localparam int clk_period    = 40;
    localparam int drive_delay   = 5;
    localparam int reset_cycles  = 3;
    localparam int sparse_cycles = 400;
    localparam int medium_cycles = 800;
    localparam int full_cycles   = 600;
    localparam int drain_margin  = 200;
    localparam int watchdog_cycles = reset_cycles + sparse_cycles + medium_cycles
                                   + full_cycles + drain_margin;
    localparam int max_results   = 8192;

    // FU slots of each bus half in ascending order
    localparam int half_slots [num_cdb][half_fu_size] = '{
        '{0, 2, 4, 6, 9, 11, 12, 14, 17, 19},
        '{1, 3, 5, 7, 8, 10, 13, 15, 16, 18}
    };

    logic        clock;
    logic        reset;
    fu_mask_t    fu_done;
    fu_result_t  fu_result [fu_size];
    fu_mask_t    fu_ready;
    cdb_packet_t cdb_0;
    cdb_packet_t cdb_1;
    cdb_packet_t bus [num_cdb];

    // Reference state of the result buffers
    fu_mask_t    m_valid;
    fu_result_t  m_res     [fu_size];
    cdb_packet_t bus_next  [num_cdb];
    cdb_packet_t exp_bus   [num_cdb];
    fu_mask_t    exp_ready;
    int          rot_pos;

    logic [31:0] lcg_state;
    int          issued;
    int          delivered;
    int          seen [max_results];
    int          mismatch_errors;
    int          other_errors;

    assign bus[0] = cdb_0;
    assign bus[1] = cdb_1;

    complete_stage i_complete_stage (
        .clock    (clock),
        .reset    (reset),
        .fu_done  (fu_done),
        .fu_result(fu_result),
        .fu_ready (fu_ready),
        .cdb_0    (cdb_0),
        .cdb_1    (cdb_1)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(clk_period / 2) clock = ~clock;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int category_of(input int slot);
        if (slot < alu_offset) begin
            return 0;
        end else if (slot < ls_offset) begin
            return 1;
        end else if (slot < mult_offset) begin
            return 2;
        end
        return 3;
    endfunction

    function automatic logic in_half(input fu_num_t slot, input int half);
        for (int p = 0; p < half_fu_size; p++) begin
            if (half_slots[half][p] == int'(slot)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Highest pending category wins, then first member at or after pos mod group size
    function automatic int pick_winner(input fu_mask_t pending, input int half, input int pos);
        int members [half_fu_size];
        int count;
        int slot;
        for (int c = fu_cat - 1; c >= 0; c--) begin
            count = 0;
            for (int p = 0; p < half_fu_size; p++) begin
                if (category_of(half_slots[half][p]) == c) begin
                    members[count] = half_slots[half][p];
                    count++;
                end
            end
            for (int j = 0; j < count; j++) begin
                slot = members[(pos + j) % count];
                if (pending[slot]) begin
                    return slot;
                end
            end
        end
        return -1;
    endfunction

    // Each ready FU finishes with probability threshold/256 per cycle
    task automatic run_phase(input int cycles, input int threshold);
        logic [31:0] r;
        for (int n = 0; n < cycles; n++) begin
            @(posedge clock);
            #drive_delay;
            for (int i = 0; i < fu_size; i++) begin
                r = lcg_next();
                fu_done[i] = 1'b0;
                if (fu_ready[i] && int'(r[23:16]) < threshold && issued < max_results) begin
                    fu_done[i]   = 1'b1;
                    fu_result[i] = '{value:   {lcg_next(), 32'(issued)},
                                     tag:     phys_reg_t'(r[29:24]),
                                     rob_idx: rob_idx_t'(issued)};
                    issued++;
                end
            end
        end
    endtask

    // Reference model runs mid-cycle where every input and output is settled
    always @(negedge clock) begin
        int       win;
        int       serial;
        fu_mask_t grant;
        if (reset) begin
            m_valid   = '0;
            rot_pos   = 0;
            exp_ready = '1;
            for (int h = 0; h < num_cdb; h++) begin
                bus_next[h] = '0;
                exp_bus[h]  = '0;
            end
        end else begin
            grant   = '0;
            exp_bus = bus_next;
            for (int h = 0; h < num_cdb; h++) begin
                win         = pick_winner(m_valid, h, rot_pos);
                bus_next[h] = '0;
                if (win >= 0) begin
                    grant[win]          = 1'b1;
                    bus_next[h].valid   = 1'b1;
                    bus_next[h].fu_num  = fu_num_t'(win);
                    bus_next[h].value   = m_res[win].value;
                    bus_next[h].tag     = m_res[win].tag;
                    bus_next[h].rob_idx = m_res[win].rob_idx;
                end
            end
            exp_ready = ~m_valid | grant;

            // Delivery bookkeeping by serial number in the low value word
            for (int h = 0; h < num_cdb; h++) begin
                if (bus[h].valid) begin
                    serial = int'(bus[h].value[31:0]);
                    assert (serial >= 0 && serial < issued)
                    else begin
                        other_errors++;
                        $display("ERROR t=%0t cdb_%0d carried a result that was never issued",
                                 $time, h);
                    end
                    if (serial >= 0 && serial < issued) begin
                        assert (seen[serial] == 0)
                        else begin
                            other_errors++;
                            $display("ERROR t=%0t result %0d appeared on a CDB again",
                                     $time, serial);
                        end
                        seen[serial]++;
                        delivered++;
                    end
                end
            end

            m_valid = (m_valid & ~grant) | fu_done;
            for (int i = 0; i < fu_size; i++) begin
                if (fu_done[i]) begin
                    m_res[i] = fu_result[i];
                end
            end
            rot_pos++;
        end
    end

    for (genvar h = 0; h < num_cdb; h++) begin : g_bus_check

        assert property (@(posedge clock) disable iff (reset)
            bus[h].valid == exp_bus[h].valid)
        else begin
            mismatch_errors++;
            $display("MISMATCH t=%0t cdb_%0d.valid got=%0b exp=%0b", $time, h,
                     $sampled(bus[h].valid), $sampled(exp_bus[h].valid));
        end

        // Category priority and rotation show up in the winner's number
        assert property (@(posedge clock) disable iff (reset)
            exp_bus[h].valid |-> bus[h].fu_num == exp_bus[h].fu_num)
        else begin
            mismatch_errors++;
            $display("MISMATCH t=%0t cdb_%0d.fu_num got=%0d exp=%0d", $time, h,
                     $sampled(bus[h].fu_num), $sampled(exp_bus[h].fu_num));
        end

        assert property (@(posedge clock) disable iff (reset)
            exp_bus[h].valid |-> bus[h].value == exp_bus[h].value)
        else begin
            mismatch_errors++;
            $display("MISMATCH t=%0t cdb_%0d.value got=%016h exp=%016h", $time, h,
                     $sampled(bus[h].value), $sampled(exp_bus[h].value));
        end

        assert property (@(posedge clock) disable iff (reset)
            exp_bus[h].valid |-> bus[h].tag == exp_bus[h].tag)
        else begin
            mismatch_errors++;
            $display("MISMATCH t=%0t cdb_%0d.tag got=%0d exp=%0d", $time, h,
                     $sampled(bus[h].tag), $sampled(exp_bus[h].tag));
        end

        assert property (@(posedge clock) disable iff (reset)
            exp_bus[h].valid |-> bus[h].rob_idx == exp_bus[h].rob_idx)
        else begin
            mismatch_errors++;
            $display("MISMATCH t=%0t cdb_%0d.rob_idx got=%0d exp=%0d", $time, h,
                     $sampled(bus[h].rob_idx), $sampled(exp_bus[h].rob_idx));
        end

        assert property (@(posedge clock) disable iff (reset)
            bus[h].valid |-> in_half(bus[h].fu_num, h))
        else begin
            other_errors++;
            $display("ERROR t=%0t cdb_%0d carried FU %0d from the other half", $time, h,
                     $sampled(bus[h].fu_num));
        end

    end

    assert property (@(posedge clock) disable iff (reset) fu_ready == exp_ready)
    else begin
        mismatch_errors++;
        $display("MISMATCH t=%0t fu_ready got=%05h exp=%05h", $time,
                 $sampled(fu_ready), $sampled(exp_ready));
    end

    // Top category never waits longer than its group rotation
    for (genvar s = mult_offset; s < beq_offset; s++) begin : g_branch_wait
        assert property (@(posedge clock) disable iff (reset) !fu_ready[s] |=> fu_ready[s])
        else begin
            other_errors++;
            $display("ERROR t=%0t branch FU %0d held for more than one cycle without a grant",
                     $time, s);
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("ERROR t=%0t watchdog expired before the results drained", $time);
        $display("mismatch errors %0d, other errors %0d, results issued %0d, delivered %0d",
                 mismatch_errors, other_errors, issued, delivered);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reset           = 1'b1;
        fu_done         = '0;
        lcg_state       = 32'h6be6;
        issued          = 0;
        delivered       = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        for (int i = 0; i < fu_size; i++) begin
            fu_result[i] = '0;
            m_res[i]     = '0;
        end
        for (int s = 0; s < max_results; s++) begin
            seen[s] = 0;
        end

        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        reset = 1'b0;
        assert (cdb_0.valid == 1'b0)
        else begin
            mismatch_errors++;
            $display("MISMATCH t=%0t cdb_0.valid got=%0b exp=0 after reset",
                     $time, cdb_0.valid);
        end
        assert (cdb_1.valid == 1'b0)
        else begin
            mismatch_errors++;
            $display("MISMATCH t=%0t cdb_1.valid got=%0b exp=0 after reset",
                     $time, cdb_1.valid);
        end
        assert (fu_ready == '1)
        else begin
            mismatch_errors++;
            $display("MISMATCH t=%0t fu_ready got=%05h exp=fffff after reset",
                     $time, fu_ready);
        end

        // Sparse traffic leaves most results alone on their half
        run_phase(sparse_cycles, 3);
        run_phase(medium_cycles, 64);
        run_phase(full_cycles, 256);

        @(posedge clock);
        #drive_delay;
        fu_done = '0;
        while (m_valid != '0 || bus_next[0].valid || bus_next[1].valid) begin
            @(posedge clock);
        end
        repeat (3) @(posedge clock);

        for (int s = 0; s < issued; s++) begin
            assert (seen[s] == 1)
            else begin
                other_errors++;
                $display("ERROR result %0d reached the CDBs %0d times", s, seen[s]);
            end
        end

        $display("mismatch errors %0d, other errors %0d, results issued %0d, delivered %0d",
                 mismatch_errors, other_errors, issued, delivered);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/cdb_pkg.sv
hdl/rotating_priority_selector.sv
hdl/fu_result_buffer.sv
hdl/fu_selector_2.sv
hdl/cdb_broadcast.sv
hdl/complete_stage.sv
verification/complete_stage_tb.sv
